//--- sim.f
+incdir+.
smartnic_app_pkg.sv
axis_fifo.sv
rss_hash_gen.sv
egr_merge.sv
smartnic_app.sv
tb_smartnic_app.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_smartnic_app -f sim.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "run_sim: build or simulation error"; exit 1; }

cat sim.log

grep -qx "Verification passed" sim.log \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }

//--- tb_smartnic_app.sv
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_app_params.svh"

module tb_smartnic_app;

    localparam int NUM_PKTS     = 12;
    localparam int MAX_BEATS    = 64;
    localparam int STALL_CYCLES = 30;
    localparam int WDOG_MARGIN  = 200;

    // bp_mode 0 always ready, 1 random ready, 2 long stall then ready
    typedef struct packed {
        logic [2:0]                   beats;
        logic [`PORT_WID-1:0]         tid;
        logic [`PORT_WID-1:0]         tdest;
        logic [`AXIS_KEEP_WID-1:0]    last_keep;
        logic                         rss_en;
        logic [1:0]                   bp_mode;
    } pkt_entry_t;

    typedef struct packed {
        logic [`AXIS_DATA_WID-1:0]    tdata;
        logic [`AXIS_KEEP_WID-1:0]    tkeep;
        logic                         tlast;
        logic [`PORT_WID-1:0]         tid;
        logic [`PORT_WID-1:0]         tdest;
        logic                         rss_en;
        logic [`RSS_ENTROPY_WID-1:0]  entropy;
    } exp_beat_t;

    logic                          core_clk;
    logic                          reset;
    logic                          rss_enable;
    logic                          axis_app_igr_tvalid;
    logic                          axis_app_igr_tready;
    logic [`AXIS_DATA_WID-1:0]     axis_app_igr_tdata;
    logic [`AXIS_KEEP_WID-1:0]     axis_app_igr_tkeep;
    logic                          axis_app_igr_tlast;
    logic [`PORT_WID-1:0]          axis_app_igr_tid;
    logic [`PORT_WID-1:0]          axis_app_igr_tdest;
    logic                          axis_app_egr_tvalid;
    logic                          axis_app_egr_tready;
    logic [`AXIS_DATA_WID-1:0]     axis_app_egr_tdata;
    logic [`AXIS_KEEP_WID-1:0]     axis_app_egr_tkeep;
    logic                          axis_app_egr_tlast;
    logic [`PORT_WID-1:0]          axis_app_egr_tid;
    logic [`PORT_WID-1:0]          axis_app_egr_tdest;
    logic                          axis_app_egr_tuser_rss_enable;
    logic [`RSS_ENTROPY_WID-1:0]   axis_app_egr_tuser_rss_entropy;

    pkt_entry_t   pkt_table [NUM_PKTS];
    exp_beat_t    stim [MAX_BEATS];
    logic         stim_rss_level [MAX_BEATS];
    exp_beat_t    exp_q [$];
    logic [31:0]  lcg_state;
    logic         gen_done;
    logic         mon_en;
    int           total_beats;
    int           rx_pkt;
    int           rx_beat;
    int           rx_total;
    int           stall_cnt;
    int           pkt_errors;
    int           error_count;
    int           igr_stall_cycles;

    smartnic_app u_smartnic_app (
        .core_clk                       ( core_clk ),
        .reset                          ( reset ),
        .rss_enable                     ( rss_enable ),
        .axis_app_igr_tvalid            ( axis_app_igr_tvalid ),
        .axis_app_igr_tready            ( axis_app_igr_tready ),
        .axis_app_igr_tdata             ( axis_app_igr_tdata ),
        .axis_app_igr_tkeep             ( axis_app_igr_tkeep ),
        .axis_app_igr_tlast             ( axis_app_igr_tlast ),
        .axis_app_igr_tid               ( axis_app_igr_tid ),
        .axis_app_igr_tdest             ( axis_app_igr_tdest ),
        .axis_app_egr_tvalid            ( axis_app_egr_tvalid ),
        .axis_app_egr_tready            ( axis_app_egr_tready ),
        .axis_app_egr_tdata             ( axis_app_egr_tdata ),
        .axis_app_egr_tkeep             ( axis_app_egr_tkeep ),
        .axis_app_egr_tlast             ( axis_app_egr_tlast ),
        .axis_app_egr_tid               ( axis_app_egr_tid ),
        .axis_app_egr_tdest             ( axis_app_egr_tdest ),
        .axis_app_egr_tuser_rss_enable  ( axis_app_egr_tuser_rss_enable ),
        .axis_app_egr_tuser_rss_entropy ( axis_app_egr_tuser_rss_entropy )
    );

    always #2 core_clk = ~core_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // XOR of five 12-bit slices, the top nibble and the source port
    function automatic logic [11:0] expected_entropy(input logic [63:0] d, input logic [3:0] id);
        return d[11:0] ^ d[23:12] ^ d[35:24] ^ d[47:36] ^ d[59:48]
             ^ {8'h00, d[63:60]} ^ {8'h00, id};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] want_val,
                                   input logic [63:0] got_val);
        $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                 $time, name, want_val, got_val);
        error_count++;
        pkt_errors++;
    endtask

    // ----------------------------------------------------------
    // Table columns are beats, tid, tdest, last tkeep, rss and bp_mode
    // ----------------------------------------------------------
    task automatic load_table();
        pkt_table[0]  = '{3'd1, 4'h1, 4'h2, 8'h0f, 1'b1, 2'd0};
        pkt_table[1]  = '{3'd3, 4'h2, 4'h3, 8'hff, 1'b1, 2'd0};
        pkt_table[2]  = '{3'd5, 4'h3, 4'h4, 8'h01, 1'b0, 2'd1};
        pkt_table[3]  = '{3'd2, 4'h4, 4'h5, 8'h3f, 1'b1, 2'd1};
        // Stall here, then 8 stored beats fill the beat FIFO
        pkt_table[4]  = '{3'd3, 4'h5, 4'h6, 8'h1f, 1'b1, 2'd2};
        pkt_table[5]  = '{3'd5, 4'h6, 4'h7, 8'h03, 1'b0, 2'd0};
        pkt_table[6]  = '{3'd2, 4'h7, 4'h8, 8'hff, 1'b1, 2'd1};
        // Stall on short packets so the metadata FIFO fills first
        pkt_table[7]  = '{3'd1, 4'h8, 4'h9, 8'hff, 1'b1, 2'd2};
        pkt_table[8]  = '{3'd1, 4'h9, 4'ha, 8'h80, 1'b0, 2'd0};
        pkt_table[9]  = '{3'd1, 4'ha, 4'hb, 8'h01, 1'b1, 2'd0};
        pkt_table[10] = '{3'd2, 4'hb, 4'hc, 8'h7f, 1'b0, 2'd0};
        pkt_table[11] = '{3'd4, 4'hc, 4'hd, 8'hff, 1'b1, 2'd1};
    endtask

    // rss_enable flips after the first beat and must not matter
    task automatic build_stimulus();
        int                           idx;
        logic [31:0]                  hi;
        logic [31:0]                  lo;
        exp_beat_t                    b;
        logic [`RSS_ENTROPY_WID-1:0]  pkt_ent;
        idx     = 0;
        pkt_ent = '0;
        for (int p = 0; p < NUM_PKTS; p++) begin
            for (int n = 0; n < int'(pkt_table[p].beats); n++) begin
                hi       = lcg_next();
                lo       = lcg_next();
                b.tdata  = {hi, lo};
                b.tlast  = (n == int'(pkt_table[p].beats) - 1);
                b.tkeep  = b.tlast ? pkt_table[p].last_keep : 8'hff;
                b.tid    = pkt_table[p].tid;
                b.tdest  = pkt_table[p].tdest;
                b.rss_en = pkt_table[p].rss_en;
                if (n == 0) begin
                    pkt_ent = b.rss_en ? expected_entropy(b.tdata, b.tid) : 12'h000;
                end
                b.entropy = pkt_ent;
                stim[idx] = b;
                stim_rss_level[idx] = (n == 0) ? b.rss_en : !b.rss_en;
                exp_q.push_back(b);
                idx++;
            end
        end
        total_beats = idx;
    endtask

    // ----------------------------------------------------------
    // Egress ready and monitor
    // ----------------------------------------------------------
    always @(negedge core_clk) begin
        logic [31:0]  rnd;
        logic         ready;
        exp_beat_t    want;
        if (mon_en) begin
            ready = 1'b1;
            if (rx_pkt < NUM_PKTS) begin
                if (pkt_table[rx_pkt].bp_mode == 2'd1) begin
                    rnd   = lcg_next();
                    ready = rnd[16];
                end else if (pkt_table[rx_pkt].bp_mode == 2'd2 && rx_beat == 0 &&
                             stall_cnt < STALL_CYCLES) begin
                    ready = 1'b0;
                    if (axis_app_egr_tvalid) begin
                        stall_cnt++;
                    end
                end
            end
            axis_app_egr_tready = ready;
            if (axis_app_egr_tvalid && ready) begin
                if (exp_q.size() == 0) begin
                    $display("time=%0t: egress delivered a beat that was never sent", $time);
                    error_count++;
                end else begin
                    want = exp_q.pop_front();
                    if (axis_app_egr_tdata !== want.tdata)
                        report_mismatch("axis_app_egr_tdata", want.tdata, axis_app_egr_tdata);
                    if (axis_app_egr_tkeep !== want.tkeep)
                        report_mismatch("axis_app_egr_tkeep", 64'(want.tkeep),
                                        64'(axis_app_egr_tkeep));
                    if (axis_app_egr_tlast !== want.tlast)
                        report_mismatch("axis_app_egr_tlast", 64'(want.tlast),
                                        64'(axis_app_egr_tlast));
                    if (axis_app_egr_tid !== want.tid)
                        report_mismatch("axis_app_egr_tid", 64'(want.tid), 64'(axis_app_egr_tid));
                    if (axis_app_egr_tdest !== want.tdest)
                        report_mismatch("axis_app_egr_tdest", 64'(want.tdest),
                                        64'(axis_app_egr_tdest));
                    if (axis_app_egr_tuser_rss_enable !== want.rss_en)
                        report_mismatch("axis_app_egr_tuser_rss_enable", 64'(want.rss_en),
                                        64'(axis_app_egr_tuser_rss_enable));
                    if (axis_app_egr_tuser_rss_entropy !== want.entropy)
                        report_mismatch("axis_app_egr_tuser_rss_entropy", 64'(want.entropy),
                                        64'(axis_app_egr_tuser_rss_entropy));
                    rx_total++;
                    if (axis_app_egr_tlast) begin
                        $display("packet %0d: %0d beats, %0d errors", rx_pkt, rx_beat + 1,
                                 pkt_errors);
                        rx_pkt++;
                        rx_beat    = 0;
                        stall_cnt  = 0;
                        pkt_errors = 0;
                    end else begin
                        rx_beat++;
                    end
                end
            end
        end
    end

    // Watchdog scaled by the number of beats in the table
    initial begin
        wait (gen_done);
        repeat (total_beats * 40 + WDOG_MARGIN) @(posedge core_clk);
        $display("timeout: only %0d of %0d packets left the egress port", rx_pkt, NUM_PKTS);
        $display("Verification failed");
        $finish;
    end

    // ----------------------------------------------------------
    // Reset, reset-state check and ingress driver
    // ----------------------------------------------------------
    initial begin
        int beat_idx;
        core_clk = 1'b0;
        reset = 1'b1;
        rss_enable = 1'b0;
        axis_app_igr_tvalid = 1'b0;
        axis_app_igr_tdata = '0;
        axis_app_igr_tkeep = '0;
        axis_app_igr_tlast = 1'b0;
        axis_app_igr_tid = '0;
        axis_app_igr_tdest = '0;
        axis_app_egr_tready = 1'b0;
        lcg_state = 32'hef61028a;
        mon_en = 1'b0;
        gen_done = 1'b0;
        rx_pkt = 0;
        rx_beat = 0;
        rx_total = 0;
        stall_cnt = 0;
        pkt_errors = 0;
        error_count = 0;
        igr_stall_cycles = 0;
        load_table();
        build_stimulus();
        gen_done = 1'b1;
        repeat (2) @(negedge core_clk);
        reset = 1'b0;

        @(negedge core_clk);
        if (axis_app_egr_tvalid !== 1'b0)
            report_mismatch("axis_app_egr_tvalid", 64'(0), 64'(axis_app_egr_tvalid));
        if (axis_app_igr_tready !== 1'b1)
            report_mismatch("axis_app_igr_tready", 64'(1), 64'(axis_app_igr_tready));
        $display("reset state: %0d errors", pkt_errors);
        pkt_errors = 0;
        mon_en = 1'b1;

        // Back-to-back beats since tready depends only on stored state
        beat_idx = 0;
        while (beat_idx < total_beats) begin
            @(negedge core_clk);
            axis_app_igr_tvalid = 1'b1;
            axis_app_igr_tdata  = stim[beat_idx].tdata;
            axis_app_igr_tkeep  = stim[beat_idx].tkeep;
            axis_app_igr_tlast  = stim[beat_idx].tlast;
            axis_app_igr_tid    = stim[beat_idx].tid;
            axis_app_igr_tdest  = stim[beat_idx].tdest;
            rss_enable          = stim_rss_level[beat_idx];
            if (axis_app_igr_tready) begin
                beat_idx++;
            end else begin
                igr_stall_cycles++;
            end
        end
        @(negedge core_clk);
        axis_app_igr_tvalid = 1'b0;

        wait (rx_pkt == NUM_PKTS);
        repeat (8) @(negedge core_clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected beats never left the egress port", exp_q.size());
            error_count++;
        end
        if (igr_stall_cycles == 0) begin
            $display("ingress tready never dropped while egress was stalled");
            error_count++;
        end
        $display("summary: packets %0d, beats %0d of %0d, ingress stall cycles %0d, errors %0d",
                 rx_pkt, rx_total, total_beats, igr_stall_cycles, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_smartnic_app

`default_nettype wire

//--- smartnic_app.sv
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_app_params.svh"

module smartnic_app (
    input  wire                          core_clk,
    input  wire                          reset,

    // RSS enable level, sampled per packet
    input  wire                          rss_enable,

    // AXI-S app_igr interface
    input  wire                          axis_app_igr_tvalid,
    output logic                         axis_app_igr_tready,
    input  wire [`AXIS_DATA_WID-1:0]     axis_app_igr_tdata,
    input  wire [`AXIS_KEEP_WID-1:0]     axis_app_igr_tkeep,
    input  wire                          axis_app_igr_tlast,
    input  wire [`PORT_WID-1:0]          axis_app_igr_tid,
    input  wire [`PORT_WID-1:0]          axis_app_igr_tdest,

    // AXI-S app_egr interface
    output logic                         axis_app_egr_tvalid,
    input  wire                          axis_app_egr_tready,
    output logic [`AXIS_DATA_WID-1:0]    axis_app_egr_tdata,
    output logic [`AXIS_KEEP_WID-1:0]    axis_app_egr_tkeep,
    output logic                         axis_app_egr_tlast,
    output logic [`PORT_WID-1:0]         axis_app_egr_tid,
    output logic [`PORT_WID-1:0]         axis_app_egr_tdest,
    output logic                         axis_app_egr_tuser_rss_enable,
    output logic [`RSS_ENTROPY_WID-1:0]  axis_app_egr_tuser_rss_entropy
);

    // Beat FIFO
    logic                          beat_push;
    smartnic_app_pkg::axis_beat_t  beat_push_data;
    logic                          beat_full;
    logic                          beat_pop;
    smartnic_app_pkg::axis_beat_t  beat_pop_data;
    logic                          beat_valid;

    // Metadata FIFO
    logic                          meta_push;
    smartnic_app_pkg::rss_meta_t   meta_push_data;
    logic                          meta_full;
    logic                          meta_pop;
    smartnic_app_pkg::rss_meta_t   meta_pop_data;
    logic                          meta_valid;

    // ----------------------------------------------------------
    // Ingress acceptance and hashing
    // ----------------------------------------------------------
    rss_hash_gen u_rss_hash_gen (
        .core_clk   ( core_clk ),
        .reset      ( reset ),
        .rss_enable ( rss_enable ),
        .igr_tvalid ( axis_app_igr_tvalid ),
        .igr_tready ( axis_app_igr_tready ),
        .igr_tdata  ( axis_app_igr_tdata ),
        .igr_tkeep  ( axis_app_igr_tkeep ),
        .igr_tlast  ( axis_app_igr_tlast ),
        .igr_tid    ( axis_app_igr_tid ),
        .igr_tdest  ( axis_app_igr_tdest ),
        .beat_full  ( beat_full ),
        .meta_full  ( meta_full ),
        .beat_push  ( beat_push ),
        .beat_data  ( beat_push_data ),
        .meta_push  ( meta_push ),
        .meta_data  ( meta_push_data )
    );

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    axis_fifo #(
        .payload_t ( smartnic_app_pkg::axis_beat_t ),
        .DEPTH     ( `BEAT_FIFO_DEPTH )
    ) u_beat_fifo (
        .core_clk  ( core_clk ),
        .reset     ( reset ),
        .push      ( beat_push ),
        .push_data ( beat_push_data ),
        .full      ( beat_full ),
        .pop       ( beat_pop ),
        .pop_data  ( beat_pop_data ),
        .valid     ( beat_valid )
    );

    // One entry per packet
    axis_fifo #(
        .payload_t ( smartnic_app_pkg::rss_meta_t ),
        .DEPTH     ( `META_FIFO_DEPTH )
    ) u_meta_fifo (
        .core_clk  ( core_clk ),
        .reset     ( reset ),
        .push      ( meta_push ),
        .push_data ( meta_push_data ),
        .full      ( meta_full ),
        .pop       ( meta_pop ),
        .pop_data  ( meta_pop_data ),
        .valid     ( meta_valid )
    );

    // ----------------------------------------------------------
    // Egress merge
    // ----------------------------------------------------------
    egr_merge u_egr_merge (
        .beat_valid            ( beat_valid ),
        .beat_data             ( beat_pop_data ),
        .beat_pop              ( beat_pop ),
        .meta_valid            ( meta_valid ),
        .meta_data             ( meta_pop_data ),
        .meta_pop              ( meta_pop ),
        .egr_tvalid            ( axis_app_egr_tvalid ),
        .egr_tready            ( axis_app_egr_tready ),
        .egr_tdata             ( axis_app_egr_tdata ),
        .egr_tkeep             ( axis_app_egr_tkeep ),
        .egr_tlast             ( axis_app_egr_tlast ),
        .egr_tid               ( axis_app_egr_tid ),
        .egr_tdest             ( axis_app_egr_tdest ),
        .egr_tuser_rss_enable  ( axis_app_egr_tuser_rss_enable ),
        .egr_tuser_rss_entropy ( axis_app_egr_tuser_rss_entropy )
    );

endmodule : smartnic_app

`default_nettype wire

//--- egr_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_app_params.svh"

module egr_merge (
    // Beat FIFO read side
    input  wire                                 beat_valid,
    input  wire smartnic_app_pkg::axis_beat_t   beat_data,
    output logic                                beat_pop,

    // Metadata FIFO read side
    input  wire                                 meta_valid,
    input  wire smartnic_app_pkg::rss_meta_t    meta_data,
    output logic                                meta_pop,

    // Egress stream
    output logic                                egr_tvalid,
    input  wire                                 egr_tready,
    output logic [`AXIS_DATA_WID-1:0]           egr_tdata,
    output logic [`AXIS_KEEP_WID-1:0]           egr_tkeep,
    output logic                                egr_tlast,
    output logic [`PORT_WID-1:0]                egr_tid,
    output logic [`PORT_WID-1:0]                egr_tdest,
    output logic                                egr_tuser_rss_enable,
    output logic [`RSS_ENTROPY_WID-1:0]         egr_tuser_rss_entropy
);

    logic xfer;

    // ----------------------------------------------------------
    // Handshake
    // ----------------------------------------------------------
    // Metadata is pushed on the first beat, so a stored beat may
    // briefly wait on its entry; hold valid until both are there
    assign egr_tvalid = beat_valid && meta_valid;
    assign xfer       = egr_tvalid && egr_tready;

    // Every transfer consumes a beat
    assign beat_pop = xfer;

    // Metadata stays at the head for the whole packet
    assign meta_pop = xfer && beat_data.tlast;

    // ----------------------------------------------------------
    // Egress payload
    // ----------------------------------------------------------
    // Both FIFO outputs are stable while valid is high and
    // nothing pops, so the beat holds until ready
    assign egr_tdata  = beat_data.tdata;
    assign egr_tkeep  = beat_data.tkeep;
    assign egr_tlast  = beat_data.tlast;
    assign egr_tid    = beat_data.tid;
    assign egr_tdest  = beat_data.tdest;

    // Same metadata on every beat of the packet
    assign egr_tuser_rss_enable  = meta_data.rss_enable;
    assign egr_tuser_rss_entropy = meta_data.rss_entropy;

endmodule : egr_merge

`default_nettype wire

//--- rss_hash_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_app_params.svh"

module rss_hash_gen (
    input  wire                           core_clk,
    input  wire                           reset,

    // Sampled on each first beat
    input  wire                           rss_enable,

    // Ingress stream
    input  wire                           igr_tvalid,
    output logic                          igr_tready,
    input  wire [`AXIS_DATA_WID-1:0]      igr_tdata,
    input  wire [`AXIS_KEEP_WID-1:0]      igr_tkeep,
    input  wire                           igr_tlast,
    input  wire [`PORT_WID-1:0]           igr_tid,
    input  wire [`PORT_WID-1:0]           igr_tdest,

    // FIFO write sides
    input  wire                           beat_full,
    input  wire                           meta_full,
    output logic                          beat_push,
    output smartnic_app_pkg::axis_beat_t  beat_data,
    output logic                          meta_push,
    output smartnic_app_pkg::rss_meta_t   meta_data
);

    localparam int DATA_WID  = `AXIS_DATA_WID;
    localparam int ENT_WID   = `RSS_ENTROPY_WID;
    localparam int NUM_SLICE = DATA_WID / ENT_WID;
    localparam int REM_WID   = DATA_WID % ENT_WID;

    logic                 first_beat;
    logic                 accept;
    logic [ENT_WID-1:0]   entropy;

    // Folded XOR of the first beat and its source port
    function automatic logic [ENT_WID-1:0] fold_hash(
        input logic [DATA_WID-1:0]    tdata,
        input logic [`PORT_WID-1:0]   tid
    );
        logic [ENT_WID-1:0] acc;
        acc = '0;
        for (int i = 0; i < NUM_SLICE; i++) begin
            acc = acc ^ tdata[i*ENT_WID +: ENT_WID];
        end
        // Leftover top bits, zero-extended
        acc = acc ^ ENT_WID'(tdata[DATA_WID-1 -: REM_WID]);
        acc = acc ^ ENT_WID'(tid);
        return acc;
    endfunction

    // ----------------------------------------------------------
    // Acceptance
    // ----------------------------------------------------------
    // A first beat also needs room for its metadata entry
    assign igr_tready = !beat_full && (!first_beat || !meta_full);
    assign accept     = igr_tvalid && igr_tready;

    always_ff @(posedge core_clk) begin
        if (reset) begin
            first_beat <= 1'b1;
        end else if (accept) begin
            first_beat <= igr_tlast;
        end
    end

    // ----------------------------------------------------------
    // FIFO pushes
    // ----------------------------------------------------------
    assign beat_push       = accept;
    assign beat_data.tdata = igr_tdata;
    assign beat_data.tkeep = igr_tkeep;
    assign beat_data.tlast = igr_tlast;
    assign beat_data.tid   = igr_tid;
    assign beat_data.tdest = igr_tdest;

    assign entropy               = fold_hash(igr_tdata, igr_tid);
    assign meta_push             = accept && first_beat;
    assign meta_data.rss_enable  = rss_enable;
    assign meta_data.rss_entropy = rss_enable ? entropy : '0;

endmodule : rss_hash_gen

`default_nettype wire

//--- axis_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module axis_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  wire           core_clk,
    input  wire           reset,

    // Write side
    input  wire           push,
    input  wire payload_t push_data,
    output logic          full,

    // Read side, show-ahead
    input  wire           pop,
    output payload_t      pop_data,
    output logic          valid
);

    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH];
    logic [PTR_WID-1:0]   wr_ptr;
    logic [PTR_WID-1:0]   rd_ptr;
    logic [CNT_WID-1:0]   count;
    logic                 wr_en;
    logic                 rd_en;

    // Wrap at DEPTH so non power-of-two depths also work
    function automatic logic [PTR_WID-1:0] next_ptr(input logic [PTR_WID-1:0] ptr);
        if (ptr == PTR_WID'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full  = (count == CNT_WID'(DEPTH));
    assign valid = (count != '0);
    assign wr_en = push && !full;
    assign rd_en = pop && valid;

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Oldest entry is always on the output
    assign pop_data = mem[rd_ptr];

    // ----------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leaves the count alone
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : axis_fifo

`default_nettype wire

//--- smartnic_app_pkg.sv
`default_nettype none

`include "smartnic_app_params.svh"

package smartnic_app_pkg;

    // ----------------------------------------------------------
    // Stream beat as stored in the beat FIFO
    // ----------------------------------------------------------
    typedef struct packed {
        logic [`AXIS_DATA_WID-1:0]    tdata;
        logic [`AXIS_KEEP_WID-1:0]    tkeep;
        logic                         tlast;
        logic [`PORT_WID-1:0]         tid;
        logic [`PORT_WID-1:0]         tdest;
    } axis_beat_t;

    // ----------------------------------------------------------
    // Per-packet RSS metadata
    // ----------------------------------------------------------
    // Zero entropy whenever rss_enable is clear
    typedef struct packed {
        logic                         rss_enable;
        logic [`RSS_ENTROPY_WID-1:0]  rss_entropy;
    } rss_meta_t;

endpackage : smartnic_app_pkg

`default_nettype wire

//--- smartnic_app_params.svh
`ifndef SMARTNIC_APP_PARAMS_SVH
`define SMARTNIC_APP_PARAMS_SVH

// ----------------------------------------------------------
// AXI-Stream data path
// ----------------------------------------------------------
`define AXIS_DATA_WID     64
`define AXIS_KEEP_WID     8
`define PORT_WID          4

// RSS hash output width
`define RSS_ENTROPY_WID   12

// ----------------------------------------------------------
// FIFO depths, in entries
// ----------------------------------------------------------
`define BEAT_FIFO_DEPTH   8
`define META_FIFO_DEPTH   4

`endif
